// ==== design/coreDefs.sv ====
package coreDefs;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int RegCount = 32;
	localparam int InstrWidth = 32;

	// Queue depth, also the sender's starting credits
	localparam int QueueDepth = 4;
	localparam int QueuePtrWidth = $clog2(QueueDepth);
	localparam int QueueCountWidth = $clog2(QueueDepth + 1);

	localparam int ResultCredits = 4;
	localparam int ResultCreditWidth = $clog2(ResultCredits + 1);

	// Opcodes
	localparam logic [5:0] OpSpecial = 6'b000000;
	localparam logic [5:0] OpAddi = 6'b001000;
	localparam logic [5:0] OpAddiu = 6'b001001;
	localparam logic [5:0] OpSlti = 6'b001010;
	localparam logic [5:0] OpSltiu = 6'b001011;
	localparam logic [5:0] OpAndi = 6'b001100;
	localparam logic [5:0] OpOri = 6'b001101;
	localparam logic [5:0] OpXori = 6'b001110;
	localparam logic [5:0] OpLui = 6'b001111;

	// Funct field, R-type only
	localparam logic [5:0] FnSll = 6'b000000;
	localparam logic [5:0] FnSrl = 6'b000010;
	localparam logic [5:0] FnSra = 6'b000011;
	localparam logic [5:0] FnAdd = 6'b100000;
	localparam logic [5:0] FnAddu = 6'b100001;
	localparam logic [5:0] FnSub = 6'b100010;
	localparam logic [5:0] FnSubu = 6'b100011;
	localparam logic [5:0] FnAnd = 6'b100100;
	localparam logic [5:0] FnOr = 6'b100101;
	localparam logic [5:0] FnXor = 6'b100110;
	localparam logic [5:0] FnNor = 6'b100111;
	localparam logic [5:0] FnSlt = 6'b101010;
	localparam logic [5:0] FnSltu = 6'b101011;

	typedef enum logic [3:0] {
		AluAdd, // ADD and ADDU share it, no overflow trap
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluNor,
		AluSlt,
		AluSltu,
		AluSll,
		AluSrl,
		AluSra,
		AluLui
	} aluOpType;

	typedef logic [InstrWidth-1:0] instrWord;

	typedef struct packed {
		logic [RegAddrWidth-1:0] dst;
		logic [DataWidth-1:0] data;
	} wbRecord;

endpackage

// ==== design/creditFifo.sv ====
`timescale 1ns/10ps

module creditFifo #(
	parameter type payloadType = logic
) (
	input  logic CLK,
	input  logic reset,
	input  logic push,
	input  payloadType pushData,
	input  logic pop,
	output logic avail,
	output logic full,
	output payloadType headData
);
	import coreDefs::*;

	payloadType mem [QueueDepth];
	logic [QueuePtrWidth-1:0] rdPtr;
	logic [QueuePtrWidth-1:0] wrPtr;
	logic [QueueCountWidth-1:0] count;
	logic doPush;
	logic doPop;

	assign avail = (count != '0);
	assign full = (count == QueueCountWidth'(QueueDepth));
	assign doPush = push && !full; // Sender never overruns its credits
	assign doPop = pop && avail;
	assign headData = mem[rdPtr];

	always_ff @(posedge CLK) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == QueuePtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
	input  logic CLK,
	input  logic reset,
	input  logic [coreDefs::RegAddrWidth-1:0] rdAddrA,
	input  logic [coreDefs::RegAddrWidth-1:0] rdAddrB,
	output logic [coreDefs::DataWidth-1:0] rdDataA,
	output logic [coreDefs::DataWidth-1:0] rdDataB,
	input  logic wrEn,
	input  logic [coreDefs::RegAddrWidth-1:0] wrAddr,
	input  logic [coreDefs::DataWidth-1:0] wrData
);
	import coreDefs::*;

	logic [DataWidth-1:0] regs [RegCount];

	// Register 0 reads as zero whatever the array holds
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
	input  logic CLK,
	input  logic reset,
	input  logic instrAvail,
	input  coreDefs::instrWord instrHead,
	output logic instrPop,
	output logic [coreDefs::RegAddrWidth-1:0] rdAddrA,
	output logic [coreDefs::RegAddrWidth-1:0] rdAddrB,
	input  logic [coreDefs::DataWidth-1:0] rdDataA,
	input  logic [coreDefs::DataWidth-1:0] rdDataB,
	input  logic relValid,
	input  logic [coreDefs::RegAddrWidth-1:0] relDst,
	input  logic exHold,
	output logic exValid,
	output coreDefs::aluOpType exOp,
	output logic [coreDefs::DataWidth-1:0] exA,
	output logic [coreDefs::DataWidth-1:0] exB,
	output logic [coreDefs::RegAddrWidth-1:0] exDst
);
	import coreDefs::*;

	typedef enum logic [1:0] {BReg, BShamt, BSignImm, BZeroImm} bSelType;

	logic [5:0] opcode;
	logic [RegAddrWidth-1:0] rs;
	logic [RegAddrWidth-1:0] rt;
	logic [RegAddrWidth-1:0] rd;
	logic [4:0] sa;
	logic [15:0] imm16;
	logic [5:0] funct;

	aluOpType op;
	bSelType bSel;
	logic legal;
	logic useA;
	logic shiftForm;
	logic dstRd;
	logic [RegAddrWidth-1:0] dst;
	logic [DataWidth-1:0] operandB;
	logic [RegCount-1:0] busy; // One bit per register with a write in flight
	logic hazard;
	logic moveOn;
	logic dispatch;

	assign opcode = instrHead[31:26];
	assign rs = instrHead[25:21];
	assign rt = instrHead[20:16];
	assign rd = instrHead[15:11];
	assign sa = instrHead[10:6];
	assign imm16 = instrHead[15:0];
	assign funct = instrHead[5:0];

	// ALU control from opcode and funct
	always_comb begin
		op = AluAdd;
		bSel = BSignImm;
		legal = 1'b1;
		useA = 1'b1;
		shiftForm = 1'b0;
		dstRd = 1'b0;
		case (opcode)
			OpSpecial: begin
				bSel = BReg;
				dstRd = 1'b1;
				case (funct)
					FnAdd, FnAddu: op = AluAdd;
					FnSub, FnSubu: op = AluSub;
					FnAnd: op = AluAnd;
					FnOr: op = AluOr;
					FnXor: op = AluXor;
					FnNor: op = AluNor;
					FnSlt: op = AluSlt;
					FnSltu: op = AluSltu;
					FnSll: op = AluSll;
					FnSrl: op = AluSrl;
					FnSra: op = AluSra;
					default: legal = 1'b0;
				endcase
				if (op inside {AluSll, AluSrl, AluSra}) begin
					shiftForm = 1'b1; // A comes from rt, B is sa
					bSel = BShamt;
				end
			end
			OpAddi, OpAddiu: op = AluAdd;
			OpSlti: op = AluSlt;
			OpSltiu: op = AluSltu;
			OpAndi: begin
				op = AluAnd;
				bSel = BZeroImm;
			end
			OpOri: begin
				op = AluOr;
				bSel = BZeroImm;
			end
			OpXori: begin
				op = AluXor;
				bSel = BZeroImm;
			end
			OpLui: begin
				op = AluLui;
				bSel = BZeroImm;
				useA = 1'b0;
			end
			default: legal = 1'b0;
		endcase
	end

	assign rdAddrA = shiftForm ? rt : rs;
	assign rdAddrB = rt;
	assign dst = dstRd ? rd : rt;

	always_comb begin
		case (bSel)
			BReg: operandB = rdDataB;
			BShamt: operandB = {{(DataWidth - 5){1'b0}}, sa};
			BSignImm: operandB = {{(DataWidth - 16){imm16[15]}}, imm16};
			default: operandB = {{(DataWidth - 16){1'b0}}, imm16};
		endcase
	end

	// Destination check too, so an older release cannot clear a younger write
	assign hazard = (useA && busy[rdAddrA]) || (bSel == BReg && busy[rdAddrB]) || busy[dst];
	assign moveOn = !exValid || !exHold;
	assign dispatch = instrAvail && legal && moveOn && !hazard;
	assign instrPop = dispatch || (instrAvail && !legal); // Unsupported words just drop

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (relValid) begin
				busy[relDst] <= 1'b0;
			end
			if (dispatch && dst != '0) begin
				busy[dst] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			exValid <= 1'b0;
		end else if (moveOn) begin
			exValid <= dispatch;
		end
	end

	always_ff @(posedge CLK) begin
		if (dispatch) begin
			exOp <= op;
			exA <= rdDataA;
			exB <= operandB;
			exDst <= dst;
		end
	end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input  logic CLK,
	input  logic reset,
	input  logic exValid,
	input  coreDefs::aluOpType exOp,
	input  logic [coreDefs::DataWidth-1:0] exA,
	input  logic [coreDefs::DataWidth-1:0] exB,
	input  logic [coreDefs::RegAddrWidth-1:0] exDst,
	output logic exHold,
	input  logic resHold,
	output logic resValid,
	output logic [coreDefs::RegAddrWidth-1:0] resDst,
	output logic [coreDefs::DataWidth-1:0] resData
);
	import coreDefs::*;

	logic [DataWidth-1:0] aluResult;
	logic [4:0] shamt;

	assign shamt = exB[4:0];

	// Stuck only while a finished result cannot leave
	assign exHold = resValid && resHold;

	always_comb begin
		case (exOp)
			AluAdd: aluResult = exA + exB; // Wraps, no overflow flag
			AluSub: aluResult = exA - exB;
			AluAnd: aluResult = exA & exB;
			AluOr: aluResult = exA | exB;
			AluXor: aluResult = exA ^ exB;
			AluNor: aluResult = ~(exA | exB);
			AluSlt: aluResult = {{(DataWidth - 1){1'b0}}, $signed(exA) < $signed(exB)};
			AluSltu: aluResult = {{(DataWidth - 1){1'b0}}, exA < exB};
			AluSll: aluResult = exA << shamt;
			AluSrl: aluResult = exA >> shamt;
			AluSra: aluResult = $unsigned($signed(exA) >>> shamt);
			AluLui: aluResult = exB << 16;
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			resValid <= 1'b0;
		end else if (!exHold) begin
			resValid <= exValid;
		end
	end

	always_ff @(posedge CLK) begin
		if (!exHold && exValid) begin
			resDst <= exDst;
			resData <= aluResult;
		end
	end

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/10ps

module resultStage (
	input  logic CLK,
	input  logic reset,
	input  logic resValid,
	input  logic [coreDefs::RegAddrWidth-1:0] resDst,
	input  logic [coreDefs::DataWidth-1:0] resData,
	output logic resHold,
	output logic wrEn,
	output logic [coreDefs::RegAddrWidth-1:0] wrAddr,
	output logic [coreDefs::DataWidth-1:0] wrData,
	output logic relValid,
	output logic [coreDefs::RegAddrWidth-1:0] relDst,
	input  logic wbCredit,
	output logic wbValid,
	output logic [coreDefs::RegAddrWidth-1:0] wbReg,
	output logic [coreDefs::DataWidth-1:0] wbData
);
	import coreDefs::*;

	wbRecord pushRec;
	wbRecord headRec;
	logic accept;
	logic queueAvail;
	logic queueFull;
	logic send;
	logic [ResultCreditWidth-1:0] credits;

	assign resHold = queueFull;
	assign accept = resValid && !queueFull;

	// Write back and release the scoreboard in the accepting cycle
	assign wrEn = accept;
	assign wrAddr = resDst;
	assign wrData = resData;
	assign relValid = accept;
	assign relDst = resDst;

	assign pushRec = '{dst: resDst, data: resData}; // r0 still reported with its data

	creditFifo #(
		.payloadType(wbRecord)
	) resultQueue (
		.CLK(CLK),
		.reset(reset),
		.push(accept),
		.pushData(pushRec),
		.pop(send),
		.avail(queueAvail),
		.full(queueFull),
		.headData(headRec)
	);

	assign send = queueAvail && credits != '0;

	always_ff @(posedge CLK) begin
		if (reset) begin
			wbValid <= 1'b0;
			credits <= ResultCreditWidth'(ResultCredits);
		end else begin
			wbValid <= send;
			case ({wbCredit, send})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits; // Both or neither
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (send) begin
			wbReg <= headRec.dst;
			wbData <= headRec.data;
		end
	end

endmodule

// ==== design/aluCore.sv ====
`timescale 1ns/10ps

module aluCore (
	input  logic CLK,
	input  logic reset,
	input  logic instrValid,
	input  logic [coreDefs::InstrWidth-1:0] instrData,
	output logic instrCredit,
	output logic wbValid,
	output logic [coreDefs::RegAddrWidth-1:0] wbReg,
	output logic [coreDefs::DataWidth-1:0] wbData,
	input  logic wbCredit
);
	import coreDefs::*;

	logic instrAvail;
	instrWord instrHead;

	logic [RegAddrWidth-1:0] rdAddrA;
	logic [RegAddrWidth-1:0] rdAddrB;
	logic [DataWidth-1:0] rdDataA;
	logic [DataWidth-1:0] rdDataB;
	logic wrEn;
	logic [RegAddrWidth-1:0] wrAddr;
	logic [DataWidth-1:0] wrData;
	logic relValid;
	logic [RegAddrWidth-1:0] relDst;

	logic exValid;
	aluOpType exOp;
	logic [DataWidth-1:0] exA;
	logic [DataWidth-1:0] exB;
	logic [RegAddrWidth-1:0] exDst;
	logic exHold;

	logic resValid;
	logic [RegAddrWidth-1:0] resDst;
	logic [DataWidth-1:0] resData;
	logic resHold;

	// Each pop hands one credit back to the sender
	creditFifo #(
		.payloadType(instrWord)
	) instrQueue (
		.CLK(CLK),
		.reset(reset),
		.push(instrValid),
		.pushData(instrData),
		.pop(instrCredit),
		.avail(instrAvail),
		.full(),
		.headData(instrHead)
	);

	decodeStage decode (
		.CLK(CLK),
		.reset(reset),
		.instrAvail(instrAvail),
		.instrHead(instrHead),
		.instrPop(instrCredit),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.relValid(relValid),
		.relDst(relDst),
		.exHold(exHold),
		.exValid(exValid),
		.exOp(exOp),
		.exA(exA),
		.exB(exB),
		.exDst(exDst)
	);

	registerFile regFile (
		.CLK(CLK),
		.reset(reset),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	executeStage execute (
		.CLK(CLK),
		.reset(reset),
		.exValid(exValid),
		.exOp(exOp),
		.exA(exA),
		.exB(exB),
		.exDst(exDst),
		.exHold(exHold),
		.resHold(resHold),
		.resValid(resValid),
		.resDst(resDst),
		.resData(resData)
	);

	resultStage result (
		.CLK(CLK),
		.reset(reset),
		.resValid(resValid),
		.resDst(resDst),
		.resData(resData),
		.resHold(resHold),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.relValid(relValid),
		.relDst(relDst),
		.wbCredit(wbCredit),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

// ==== tb/aluCoreModel.svh ====
`ifndef ALU_CORE_MODEL_SVH
`define ALU_CORE_MODEL_SVH

// Reference register file, register 0 is never written
logic [DataWidth-1:0] modelRegs [RegCount];

function automatic void clearModel();
	for (int i = 0; i < RegCount; i++) begin
		modelRegs[i] = '0;
	end
endfunction

// Applies one instruction in program order, returns 1 if it yields a record
function automatic logic applyInstr(input instrWord instr, output wbRecord rec);
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] sa;
	logic [DataWidth-1:0] a;
	logic [DataWidth-1:0] b;
	logic [DataWidth-1:0] sImm;
	logic [DataWidth-1:0] zImm;
	logic [DataWidth-1:0] data;
	logic [RegAddrWidth-1:0] dst;
	logic ok;
	opcode = instr[31:26];
	funct = instr[5:0];
	sa = instr[10:6];
	a = modelRegs[instr[25:21]]; // rs
	b = modelRegs[instr[20:16]]; // rt
	sImm = {{16{instr[15]}}, instr[15:0]};
	zImm = {16'h0000, instr[15:0]};
	dst = instr[20:16];
	data = '0;
	ok = 1'b1;
	case (opcode)
		OpSpecial: begin
			dst = instr[15:11];
			case (funct)
				FnAdd, FnAddu: data = a + b;
				FnSub, FnSubu: data = a - b;
				FnAnd: data = a & b;
				FnOr: data = a | b;
				FnXor: data = a ^ b;
				FnNor: data = ~(a | b);
				FnSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FnSltu: data = (a < b) ? 32'd1 : 32'd0;
				FnSll: data = b << sa; // Shifts take rt
				FnSrl: data = b >> sa;
				FnSra: data = $signed(b) >>> sa;
				default: ok = 1'b0;
			endcase
		end
		OpAddi, OpAddiu: data = a + sImm;
		OpSlti: data = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
		OpSltiu: data = (a < sImm) ? 32'd1 : 32'd0;
		OpAndi: data = a & zImm;
		OpOri: data = a | zImm;
		OpXori: data = a ^ zImm;
		OpLui: data = {instr[15:0], 16'h0000};
		default: ok = 1'b0;
	endcase
	if (ok && dst != '0) begin
		modelRegs[dst] = data;
	end
	rec.dst = dst;
	rec.data = data;
	return ok;
endfunction

`endif

// ==== tb/aluCoreTb.sv ====
`timescale 1ns/10ps

module aluCoreTb;
	import coreDefs::*;

	`include "aluCoreModel.svh"

	localparam int NumInstrs = 400;
	localparam int SendLimit = 20000;
	localparam int DrainLimit = 4000;

	logic CLK;
	logic reset;
	logic instrValid;
	logic [InstrWidth-1:0] instrData;
	logic instrCredit;
	logic wbValid;
	logic [RegAddrWidth-1:0] wbReg;
	logic [DataWidth-1:0] wbData;
	logic wbCredit;

	integer seed;
	wbRecord expQ[$];
	logic [RegAddrWidth-1:0] lastDst;
	logic trafficStarted;
	int sendCredits;
	int sentCount;
	int creditPulses;
	int recordCount;
	int creditsReturned;
	int owed; // Records seen but not yet paid back
	int withholdLeft;
	int mismatches;
	int otherErrors;
	int timeouts;
	int cycles;

	aluCore UUT (
		.CLK(CLK),
		.reset(reset),
		.instrValid(instrValid),
		.instrData(instrData),
		.instrCredit(instrCredit),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.wbCredit(wbCredit)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Random instruction, about half the sources reuse the last destination
	function automatic instrWord pickInstr();
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [5:0] fn;
		logic [5:0] op;
		r = $random(seed);
		s = $random(seed);
		rs = r[4] ? lastDst : {2'b00, r[7:5]};
		rt = r[8] ? lastDst : {2'b00, r[11:9]};
		rd = {2'b00, r[14:12]}; // r0 included on purpose
		case (r[3:0])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
				case (s[19:16] % 4'd10)
					4'd0: fn = FnAdd;
					4'd1: fn = FnAddu;
					4'd2: fn = FnSub;
					4'd3: fn = FnSubu;
					4'd4: fn = FnAnd;
					4'd5: fn = FnOr;
					4'd6: fn = FnXor;
					4'd7: fn = FnNor;
					4'd8: fn = FnSlt;
					default: fn = FnSltu;
				endcase
				lastDst = rd;
				return {OpSpecial, rs, rt, rd, 5'd0, fn};
			end
			4'd5, 4'd6: begin
				fn = (s[17:16] == 2'd0) ? FnSll : (s[17:16] == 2'd1) ? FnSrl : FnSra;
				lastDst = rd;
				return {OpSpecial, 5'd0, rt, rd, s[24:20], fn};
			end
			4'd13, 4'd14: begin
				lastDst = rd;
				return {OpLui, 5'd0, rd, s[15:0]};
			end
			4'd15: begin
				// Branch opcode or JR funct, both unsupported
				if (s[16]) begin
					return {6'b000100, rs, rt, s[15:0]};
				end
				return {OpSpecial, rs, rt, rd, 5'd0, 6'b001000};
			end
			default: begin
				case (s[18:16])
					3'd0: op = OpAddi;
					3'd1: op = OpAddiu;
					3'd2: op = OpSlti;
					3'd3: op = OpSltiu;
					3'd4: op = OpAndi;
					3'd6: op = OpXori;
					default: op = OpOri;
				endcase
				lastDst = rd;
				return {op, rs, rd, s[15:0]};
			end
		endcase
	endfunction

	task automatic driveInstr();
		instrWord instr;
		wbRecord rec;
		logic [31:0] r;
		r = $random(seed);
		if (sentCount < NumInstrs && sendCredits > 0 && r[1:0] != 2'b00) begin
			instr = pickInstr();
			instrValid <= 1'b1;
			instrData <= instr;
			sendCredits--;
			sentCount++;
			trafficStarted = 1'b1;
			if (applyInstr(instr, rec)) begin
				expQ.push_back(rec);
			end
		end else begin
			instrValid <= 1'b0;
		end
	endtask

	// Pays back output credits, now and then holding them for a long stretch
	task automatic driveCredit();
		logic [31:0] r;
		r = $random(seed);
		if (withholdLeft > 0) begin
			withholdLeft--;
			wbCredit <= 1'b0;
		end else if (r[7:2] == 6'd0) begin
			withholdLeft = 30 + int'(r[15:10]);
			wbCredit <= 1'b0;
		end else if (owed > 0 && r[0]) begin
			wbCredit <= 1'b1;
			owed--;
		end else begin
			wbCredit <= 1'b0;
		end
	endtask

	task automatic checkRecord();
		wbRecord expRec;
		recordCount++;
		owed++;
		if (recordCount > ResultCredits + creditsReturned) begin
			$display("Record %0d at %0t was sent without an output credit", recordCount, $time);
			otherErrors++;
		end
		if (expQ.size() == 0) begin
			$display("Unexpected record for r%0d at %0t, none was expected", wbReg, $time);
			otherErrors++;
		end else begin
			expRec = expQ.pop_front();
			if (wbReg != expRec.dst || wbData != expRec.data) begin
				$display("Mismatch at %0t: record %0d gave r%0d = %h, expected r%0d = %h",
					$time, recordCount, wbReg, wbData, expRec.dst, expRec.data);
				mismatches++;
			end
		end
	endtask

	// Outputs sampled mid-cycle where they are settled
	always @(negedge CLK) begin
		if (!reset) begin
			if (!trafficStarted && (wbValid || instrCredit)) begin
				$display("Output active at %0t before any instruction was sent", $time);
				otherErrors++;
			end
			if (wbValid) begin
				checkRecord();
			end
			if (wbCredit) begin
				creditsReturned++;
			end
			if (instrCredit) begin
				creditPulses++;
				sendCredits++;
				if (creditPulses > sentCount || sendCredits > QueueDepth) begin
					$display("Input credit returned at %0t for no sent instruction", $time);
					otherErrors++;
				end
			end
		end
	end

	initial begin
		seed = 70;
		reset = 1'b1;
		instrValid = 1'b0;
		instrData = '0;
		wbCredit = 1'b0;
		lastDst = '0;
		trafficStarted = 1'b0;
		sendCredits = QueueDepth;
		sentCount = 0;
		creditPulses = 0;
		recordCount = 0;
		creditsReturned = 0;
		owed = 0;
		withholdLeft = 0;
		mismatches = 0;
		otherErrors = 0;
		timeouts = 0;
		clearModel();
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		repeat (20) @(posedge CLK); // Quiet stretch, outputs must stay low
		cycles = 0;
		while (sentCount < NumInstrs && cycles < SendLimit) begin
			@(posedge CLK);
			driveInstr();
			driveCredit();
			cycles++;
		end
		if (sentCount < NumInstrs) begin
			$display("Timeout: only %0d of %0d instructions were sent", sentCount, NumInstrs);
			timeouts++;
		end
		cycles = 0;
		while ((expQ.size() != 0 || creditPulses != sentCount) && cycles < DrainLimit) begin
			@(posedge CLK);
			driveInstr();
			driveCredit();
			cycles++;
		end
		if (expQ.size() != 0 || creditPulses != sentCount) begin
			$display("Timeout: %0d records missing, %0d of %0d input credits returned",
				expQ.size(), creditPulses, sentCount);
			timeouts++;
		end
		repeat (20) begin
			@(posedge CLK);
			driveCredit();
		end
		$display("Report: %0d sent, %0d records, %0d mismatches, %0d other errors, %0d timeouts",
			sentCount, recordCount, mismatches, otherErrors, timeouts);
		if (mismatches + otherErrors + timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+tb
design/coreDefs.sv
design/creditFifo.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/aluCore.sv
tb/aluCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the aluCore testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module aluCoreTb -f build.f -o aluCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/aluCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0
